//--- list.f
logic/tcp_pkg.sv
logic/tcp_rx_decode.sv
logic/tcp_conn_fsm.sv
logic/tcp_tx_emit.sv
logic/tcp_server.sv
bench/tcp_server_properties.sv
bench/tcp_server_tb.sv

//--- bench/tcp_server_tb.sv
// testbench with clock, reset, segment driver, reference reply header, checkers, watchdog
`timescale 1ns/100ps

module tcp_server_tb;
    import tcp_pkg::*;

    localparam logic [31:0] init_seq = 32'h1000_0000;
    localparam logic [15:0] srv_port = 16'h0050;
    localparam logic [15:0] cli_port = 16'hc350;
    localparam logic [7:0]  f_fin    = 8'h01;
    localparam logic [7:0]  f_syn    = 8'h02;
    localparam logic [7:0]  f_rst    = 8'h04;
    localparam logic [7:0]  f_psh    = 8'h08;
    localparam logic [7:0]  f_ack    = 8'h10;
    localparam int          n_segs   = 14;
    localparam int          limit    = n_segs * (1480 + 40) + 200;

    logic         clk;
    logic         rst;
    logic [7:0]   din;
    logic         din_vld;
    logic         din_sop;
    logic         din_eop;
    logic [15:0]  server_port;
    logic         start;
    logic [7:0]   dout;
    logic         dout_vld;
    logic         dout_sop;
    logic         dout_eop;
    logic [7:0]   u_dout;
    logic         u_dout_vld;
    logic         u_dout_sop;
    logic         u_dout_eop;
    tcp_state_e   conn_state;

    logic [159:0] exp_hdr[$];
    logic [9:0]   exp_pay[$];         // sop, eop, byte
    logic [159:0] cur_hdr;
    int           hdr_idx;
    integer       seed = 32'h5071_b713;
    int           byte_errs;
    int           state_errs;
    int           flag_errs;
    int           misc_errs;
    int           cyc;
    int           eop_cyc;
    bit           lat_check;
    bit           saw_closed;
    logic [31:0]  cli_seq;
    logic [31:0]  exp_rcv;
    logic [31:0]  exp_snd;            // what the client acks
    int           len;

    tcp_server #(.init_seq(init_seq)) u_tcp_server (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [159:0] ref_header(seg_kind_e kind, logic [31:0] seq,
                                                logic [31:0] ack, logic [15:0] port);
        logic [7:0] flags;
        flags = f_ack;
        if (kind == kind_syn_ack) flags = f_ack | f_syn;
        if (kind == kind_fin_ack) flags = f_ack | f_fin;
        return {srv_port, port, seq, ack, 8'h50, flags, 16'hffff, 32'h0};
    endfunction

    task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            byte_errs++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_state(tcp_state_e got, tcp_state_e exp);
        if (got !== exp) begin
            state_errs++;
            $display("error: conn_state got %h expected %h", got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic send_segment(logic [31:0] seq, logic [7:0] flags, int doff, int pay_len,
                                bit fwd);
        logic [159:0] h;
        logic [7:0]   b;
        int           n;
        h = {cli_port, srv_port, seq, exp_snd, 4'(doff), 4'h0, flags, 16'h4000, 32'h0};
        n = doff * 4 + pay_len;
        for (int i = 0; i < n; i++) begin
            if (i < 20) begin
                b = h[159 - 8 * i -: 8];
            end else if (i < doff * 4) begin
                b = 8'h01;                // nop option
            end else begin
                b = 8'($random(seed));
                if (fwd) exp_pay.push_back({i == doff * 4, i == n - 1, b});
            end
            @(posedge clk);
            #1;
            din     = b;
            din_vld = 1'b1;
            din_sop = (i == 0);
            din_eop = (i == n - 1);
        end
        @(posedge clk);
        #1;
        din_vld = 1'b0;
        din_sop = 1'b0;
        din_eop = 1'b0;
    endtask

    // segment reaches the fsm, then any reply drains
    task automatic wait_replies();
        repeat (3) @(posedge clk);
        while (exp_hdr.size() != 0 || dout_vld) @(posedge clk);
        #1;
    endtask

    task automatic open_connection();
        logic [31:0] syn_seq;
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        check_state(conn_state, st_wait_syn);
        syn_seq = $random(seed);
        exp_rcv = syn_seq + 1;
        exp_hdr.push_back(ref_header(kind_syn_ack, init_seq, exp_rcv, cli_port));
        lat_check = 1'b1;
        send_segment(syn_seq, f_syn, 5, 0, 1'b0);
        wait_replies();
        check_state(conn_state, st_syn_rcvd);
        exp_snd = init_seq + 1;
        cli_seq = exp_rcv;
        send_segment(cli_seq, f_ack, 5, 0, 1'b0);
        wait_replies();
        check_state(conn_state, st_open);
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (din_vld && din_eop) eop_cyc = cyc;
        if (dout_vld) begin
            if (hdr_idx == 0) begin
                if (lat_check && cyc - eop_cyc != 3) begin
                    misc_errs++;
                    $display("error: dout_sop latency %h expected %h", cyc - eop_cyc, 3);
                end
                lat_check = 1'b0;
                if (exp_hdr.size() == 0) begin
                    misc_errs++;
                    $display("a reply header was sent when none was expected");
                    cur_hdr = 'x;
                end else begin
                    cur_hdr = exp_hdr.pop_front();
                end
            end
            check_flag("dout_sop", dout_sop, hdr_idx == 0);
            check_byte("dout", dout, cur_hdr[159 - 8 * hdr_idx -: 8]);
            check_flag("dout_eop", dout_eop, hdr_idx == 19);
            hdr_idx = (hdr_idx == 19) ? 0 : hdr_idx + 1;
        end
        if (u_dout_vld) begin
            if (exp_pay.size() == 0) begin
                misc_errs++;
                $display("a payload byte came out on u_dout when none was expected");
            end else begin
                check_byte("u_dout", u_dout, exp_pay[0][7:0]);
                check_flag("u_dout_sop", u_dout_sop, exp_pay[0][9]);
                check_flag("u_dout_eop", u_dout_eop, exp_pay[0][8]);
                void'(exp_pay.pop_front());
            end
        end
        if (conn_state == st_closed) saw_closed = 1'b1;
    end

    initial begin
        rst         = 1'b1;
        din         = '0;
        din_vld     = 1'b0;
        din_sop     = 1'b0;
        din_eop     = 1'b0;
        start       = 1'b0;
        server_port = srv_port;
        byte_errs   = 0;
        state_errs  = 0;
        flag_errs   = 0;
        misc_errs   = 0;
        cyc         = 0;
        eop_cyc     = 0;
        hdr_idx     = 0;
        lat_check   = 1'b0;
        saw_closed  = 1'b0;
        exp_snd     = '0;
        cli_seq     = '0;
        exp_rcv     = '0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        check_flag("dout_vld", dout_vld, 1'b0);
        check_flag("u_dout_vld", u_dout_vld, 1'b0);
        check_state(conn_state, st_idle);

        send_segment(32'h0, f_psh | f_ack, 5, 16, 1'b0);  // ignored before start
        wait_replies();
        check_state(conn_state, st_idle);

        open_connection();

        for (int k = 0; k < 5; k++) begin
            len     = 1 + ($unsigned($random(seed)) % 200);
            exp_rcv = cli_seq + len;
            exp_hdr.push_back(ref_header(kind_ack, exp_snd, exp_rcv, cli_port));
            send_segment(cli_seq, f_psh | f_ack, 5 + k % 3, len, 1'b1);
            cli_seq = exp_rcv;
            wait_replies();
        end

        len = 1 + ($unsigned($random(seed)) % 200);
        exp_hdr.push_back(ref_header(kind_ack, exp_snd, exp_rcv, cli_port));  // dup ack
        send_segment(cli_seq + 32'h100, f_psh | f_ack, 5, len, 1'b0);
        wait_replies();
        check_state(conn_state, st_open);

        exp_rcv = cli_seq + 1;
        exp_hdr.push_back(ref_header(kind_fin_ack, exp_snd, exp_rcv, cli_port));
        send_segment(cli_seq, f_fin | f_ack, 5, 0, 1'b0);
        cli_seq = exp_rcv;
        exp_snd = exp_snd + 1;
        wait_replies();
        check_state(conn_state, st_fin_wait);
        saw_closed = 1'b0;
        send_segment(cli_seq, f_ack, 5, 0, 1'b0);
        wait_replies();
        check_flag("closed seen", saw_closed, 1'b1);
        check_state(conn_state, st_idle);

        open_connection();
        saw_closed = 1'b0;
        send_segment(cli_seq, f_rst, 5, 0, 1'b0);
        wait_replies();
        check_flag("closed seen", saw_closed, 1'b1);
        check_state(conn_state, st_idle);

        if (exp_pay.size() != 0) begin
            misc_errs++;
            $display("some expected payload bytes never came out on u_dout");
        end
        $display("errors: byte %0d state %0d flag %0d other %0d",
                 byte_errs, state_errs, flag_errs, misc_errs);
        if (byte_errs + state_errs + flag_errs + misc_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("test failed");
        $finish;
    end

endmodule

//--- bench/tcp_server_properties.sv
// concurrent assertions on reply framing and emitter start, bound to the emitter
`timescale 1ns/100ps

module tcp_server_properties (
    input logic clk,
    input logic rst,
    input logic tx_start,
    input logic tx_busy,
    input logic dout_vld,
    input logic dout_sop,
    input logic dout_eop
);

    eop_after_sop: assert property (@(posedge clk) disable iff (rst)
        dout_sop |-> (!dout_eop) [*19] ##1 dout_eop)
        else $error("dout_eop did not follow dout_sop by 19 cycles");

    vld_through_hdr: assert property (@(posedge clk) disable iff (rst)
        dout_sop |-> dout_vld [*20])
        else $error("dout_vld dropped inside a reply header");

    no_start_busy: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !tx_busy)
        else $error("tx_start while tx_busy");

endmodule

bind tcp_tx_emit tcp_server_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .dout_vld (dout_vld),
    .dout_sop (dout_sop),
    .dout_eop (dout_eop)
);

//--- logic/tcp_server.sv
// server endpoint top: decode, connection FSM and reply emitter
`timescale 1ns/100ps

module tcp_server #(
    parameter logic [tcp_pkg::seq_w-1:0] init_seq = 32'h0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 din,
    input  logic                       din_vld,
    input  logic                       din_sop,
    input  logic                       din_eop,
    input  logic [tcp_pkg::port_w-1:0] server_port,
    input  logic                       start,
    output logic [7:0]                 dout,
    output logic                       dout_vld,
    output logic                       dout_sop,
    output logic                       dout_eop,
    output logic [7:0]                 u_dout,
    output logic                       u_dout_vld,
    output logic                       u_dout_sop,
    output logic                       u_dout_eop,
    output tcp_pkg::tcp_state_e        conn_state
);
    import tcp_pkg::*;

    seg_info_t        seg_info;
    logic             seg_done;
    logic [seq_w-1:0] rcv_nxt;
    logic             rx_open;
    tx_req_t          tx_req;
    logic             tx_start;
    logic             tx_busy;

    tcp_rx_decode u_rx_decode (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_vld    (din_vld),
        .din_sop    (din_sop),
        .din_eop    (din_eop),
        .rcv_nxt    (rcv_nxt),
        .rx_open    (rx_open),
        .seg_info   (seg_info),
        .seg_done   (seg_done),
        .u_dout     (u_dout),
        .u_dout_vld (u_dout_vld),
        .u_dout_sop (u_dout_sop),
        .u_dout_eop (u_dout_eop)
    );

    tcp_conn_fsm #(
        .init_seq (init_seq)
    ) u_conn_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .seg_info   (seg_info),
        .seg_done   (seg_done),
        .tx_busy    (tx_busy),
        .rcv_nxt    (rcv_nxt),
        .rx_open    (rx_open),
        .tx_req     (tx_req),
        .tx_start   (tx_start),
        .conn_state (conn_state)
    );

    tcp_tx_emit u_tx_emit (
        .clk         (clk),
        .rst         (rst),
        .server_port (server_port),
        .tx_req      (tx_req),
        .tx_start    (tx_start),
        .tx_busy     (tx_busy),
        .dout        (dout),
        .dout_vld    (dout_vld),
        .dout_sop    (dout_sop),
        .dout_eop    (dout_eop)
    );

endmodule

//--- logic/tcp_tx_emit.sv
// reply header builder and byte serialiser
`timescale 1ns/100ps

module tcp_tx_emit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [tcp_pkg::port_w-1:0] server_port,
    input  tcp_pkg::tx_req_t           tx_req,
    input  logic                       tx_start,
    output logic                       tx_busy,
    output logic [7:0]                 dout,
    output logic                       dout_vld,
    output logic                       dout_sop,
    output logic                       dout_eop
);
    import tcp_pkg::*;

    localparam int unsigned hdr_w = 8 * hdr_bytes;

    logic [hdr_w-1:0] hdr_sh;     // msb byte is on dout
    logic [4:0]       byte_cnt;
    logic             last;
    tcp_flags_t       flags;

    always_comb begin
        flags     = '0;
        flags.ack = 1'b1;         // every reply acks
        case (tx_req.kind)
            kind_syn_ack: flags.syn = 1'b1;
            kind_fin_ack: flags.fin = 1'b1;
            default: ;
        endcase
    end

    assign last     = (byte_cnt == 5'(hdr_bytes - 1));
    assign dout     = hdr_sh[hdr_w-1 -: 8];
    assign dout_vld = tx_busy;
    assign dout_sop = tx_busy & (byte_cnt == '0);
    assign dout_eop = tx_busy & last;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy  <= 1'b0;
            byte_cnt <= '0;
        end else if (tx_start) begin
            tx_busy  <= 1'b1;
            byte_cnt <= '0;
        end else if (tx_busy) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (last) tx_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_start) begin
            // checksum and urgent pointer stay zero
            hdr_sh <= {server_port, tx_req.client_port, tx_req.seq, tx_req.ack,
                       min_doff, 6'b0, flags, win_size, 16'h0000, 16'h0000};
        end else if (tx_busy) begin
            hdr_sh <= {hdr_sh[hdr_w-9:0], 8'h00};
        end
    end

endmodule

//--- logic/tcp_conn_fsm.sv
// connection state machine with sequence tracking and one pending reply
`timescale 1ns/100ps

module tcp_conn_fsm #(
    parameter logic [tcp_pkg::seq_w-1:0] init_seq = 32'h0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  tcp_pkg::seg_info_t         seg_info,
    input  logic                       seg_done,
    input  logic                       tx_busy,
    output logic [tcp_pkg::seq_w-1:0]  rcv_nxt,
    output logic                       rx_open,
    output tcp_pkg::tx_req_t           tx_req,
    output logic                       tx_start,
    output tcp_pkg::tcp_state_e        conn_state
);
    import tcp_pkg::*;

    tcp_state_e       state_nxt;
    logic [seq_w-1:0] snd_nxt;
    logic [seq_w-1:0] snd_nxt_d;
    logic [seq_w-1:0] rcv_nxt_d;
    logic [seq_w-1:0] rcv_adv;
    logic             pend;       // request waiting for the emitter
    logic             queue;
    logic             ack_ok;
    tx_req_t          req_d;

    assign rx_open  = (conn_state == st_open);
    assign tx_start = pend & ~tx_busy;
    assign ack_ok   = seg_info.flags.ack && (seg_info.ack == snd_nxt);
    assign rcv_adv  = rcv_nxt + seq_w'(seg_info.payload_len);

    always_comb begin
        state_nxt         = conn_state;
        snd_nxt_d         = snd_nxt;
        rcv_nxt_d         = rcv_nxt;
        queue             = 1'b0;
        req_d.kind        = kind_ack;
        req_d.seq         = snd_nxt;
        req_d.client_port = seg_info.client_port;
        case (conn_state)
            st_idle: begin
                if (start) state_nxt = st_wait_syn;
            end
            st_closed: begin
                if (!tx_busy && !pend) state_nxt = st_idle;
            end
            default: begin
                if (seg_done && seg_info.flags.rst) begin
                    state_nxt = st_closed;
                end else if (seg_done) begin
                    case (conn_state)
                        st_wait_syn: begin
                            if (seg_info.flags.syn) begin
                                rcv_nxt_d  = seg_info.seq + 1'b1;
                                snd_nxt_d  = init_seq + 1'b1;
                                queue      = 1'b1;
                                req_d.kind = kind_syn_ack;
                                req_d.seq  = init_seq;
                                state_nxt  = st_syn_rcvd;
                            end
                        end
                        st_syn_rcvd: begin
                            if (ack_ok) state_nxt = st_open;
                        end
                        st_open: begin
                            if (seg_info.in_order && seg_info.flags.fin) begin
                                rcv_nxt_d  = rcv_adv + 1'b1;    // fin takes one number
                                snd_nxt_d  = snd_nxt + 1'b1;
                                queue      = 1'b1;
                                req_d.kind = kind_fin_ack;
                                state_nxt  = st_fin_wait;
                            end else if (seg_info.in_order) begin
                                rcv_nxt_d = rcv_adv;
                                queue     = (seg_info.payload_len != '0);
                            end else begin
                                queue = (seg_info.payload_len != '0);  // dup ack
                            end
                        end
                        st_fin_wait: begin
                            if (ack_ok) state_nxt = st_closed;
                        end
                        default: ;
                    endcase
                end
            end
        endcase
        req_d.ack = rcv_nxt_d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            conn_state <= st_idle;
            rcv_nxt    <= '0;
            snd_nxt    <= '0;
            pend       <= 1'b0;
        end else begin
            conn_state <= state_nxt;
            rcv_nxt    <= rcv_nxt_d;
            snd_nxt    <= snd_nxt_d;
            if (queue) begin
                pend <= 1'b1;
            end else if (tx_start) begin
                pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (queue) tx_req <= req_d;
    end

endmodule

//--- logic/tcp_rx_decode.sv
// receive header parser with option skip and in-order payload forwarding
`timescale 1ns/100ps

module tcp_rx_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [7:0]                din,
    input  logic                      din_vld,
    input  logic                      din_sop,
    input  logic                      din_eop,
    input  logic [tcp_pkg::seq_w-1:0] rcv_nxt,
    input  logic                      rx_open,
    output tcp_pkg::seg_info_t        seg_info,
    output logic                      seg_done,
    output logic [7:0]                u_dout,
    output logic                      u_dout_vld,
    output logic                      u_dout_sop,
    output logic                      u_dout_eop
);
    import tcp_pkg::*;

    logic [5:0] hdr_cnt;      // header bytes seen
    logic [5:0] hdr_len;      // data offset in bytes
    logic       in_pay;
    logic       sop;
    logic [5:0] idx;
    logic       hdr_byte;
    logic       pay_byte;
    logic       first_pay;
    logic       ord_now;
    logic       fwd;

    assign sop       = din_vld & din_sop;
    assign idx       = sop ? 6'd0 : hdr_cnt;
    assign hdr_byte  = din_vld & (sop | ~in_pay);
    assign pay_byte  = din_vld & ~sop & in_pay;
    assign first_pay = pay_byte & (seg_info.payload_len == '0);

    // decided on the first payload byte, or at eop for a bare header
    assign ord_now = (in_pay && seg_info.payload_len != '0) ? seg_info.in_order
                                                            : (seg_info.seq == rcv_nxt);
    assign fwd     = pay_byte & rx_open & ord_now;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_cnt    <= '0;
            hdr_len    <= 6'(hdr_bytes);
            in_pay     <= 1'b0;
            seg_done   <= 1'b0;
            u_dout_vld <= 1'b0;
            u_dout_sop <= 1'b0;
            u_dout_eop <= 1'b0;
        end else begin
            seg_done   <= din_vld & din_eop;
            u_dout_vld <= fwd;
            u_dout_sop <= fwd & first_pay;
            u_dout_eop <= fwd & din_eop;
            if (hdr_byte) begin
                hdr_cnt <= idx + 6'd1;
                in_pay  <= (idx + 6'd1 == hdr_len);
            end
            if (sop) begin
                hdr_len <= 6'(hdr_bytes);
            end else if (hdr_byte && idx == 6'd12) begin
                // short offsets count as a plain 20-byte header
                hdr_len <= (din[7:4] < min_doff) ? 6'(hdr_bytes) : {din[7:4], 2'b00};
            end
        end
    end

    always_ff @(posedge clk) begin
        u_dout <= din;
        if (sop) begin
            seg_info.payload_len <= '0;
        end else if (pay_byte) begin
            seg_info.payload_len <= seg_info.payload_len + 1'b1;
        end
        if (first_pay || (din_vld && din_eop)) begin
            seg_info.in_order <= ord_now;
        end
        if (hdr_byte) begin
            case (idx)
                6'd0, 6'd1: seg_info.client_port <= {seg_info.client_port[7:0], din};
                6'd4, 6'd5, 6'd6, 6'd7: seg_info.seq <= {seg_info.seq[seq_w-9:0], din};
                6'd8, 6'd9, 6'd10, 6'd11: seg_info.ack <= {seg_info.ack[seq_w-9:0], din};
                6'd13: seg_info.flags <= tcp_flags_t'(din[5:0]);
                default: ;    // dst port, window, checksum, options
            endcase
        end
    end

endmodule

//--- logic/tcp_pkg.sv
// widths, header constants, flag layout, state and reply enums, segment structs
package tcp_pkg;

    localparam int unsigned seq_w     = 32;     // sequence and acknowledge numbers
    localparam int unsigned len_w     = 11;     // payload count, up to 1460 bytes
    localparam int unsigned port_w    = 16;
    localparam int unsigned hdr_bytes = 20;     // header without options

    localparam logic [15:0] win_size  = 16'hffff;
    localparam logic [3:0]  min_doff  = 4'd5;   // data offset of a bare header, in words

    // low six bits of the flags byte with fin lowest
    typedef struct packed {
        logic urg;
        logic ack;
        logic psh;
        logic rst;
        logic syn;
        logic fin;
    } tcp_flags_t;

    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_wait_syn = 3'd1,
        st_syn_rcvd = 3'd2,
        st_open     = 3'd3,
        st_fin_wait = 3'd4,
        st_closed   = 3'd5
    } tcp_state_e;

    typedef enum logic [1:0] {
        kind_syn_ack = 2'd0,
        kind_ack     = 2'd1,
        kind_fin_ack = 2'd2
    } seg_kind_e;

    // one received segment, valid with seg_done
    typedef struct packed {
        logic [seq_w-1:0]  seq;
        logic [seq_w-1:0]  ack;
        tcp_flags_t        flags;
        logic [port_w-1:0] client_port;
        logic [len_w-1:0]  payload_len;
        logic              in_order;      // seq matched rcv_nxt
    } seg_info_t;

    // one reply header to send
    typedef struct packed {
        seg_kind_e         kind;
        logic [seq_w-1:0]  seq;
        logic [seq_w-1:0]  ack;
        logic [port_w-1:0] client_port;
    } tx_req_t;

endpackage
